//--- Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "sim: run did not complete, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axi_rom_model.sv
//####################################################################
// AXI4 read-only memory model for the cache testbench
// random handshake delays, one SLVERR beat on a chosen line
//####################################################################
`timescale 1ns/1ps

module axi_rom_model #(
   parameter cache_pkg::line_addr_t ERR_LINE = '0
) (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  cache_pkg::addr_t                axi_araddr_i,
   input  logic [cache_pkg::AXI_LEN_W-1:0] axi_arlen_i,
   input  logic                            axi_arvalid_i,
   output logic                            axi_arready_o,
   output cache_pkg::beat_t                axi_rdata_o,
   output logic [1:0]                      axi_rresp_o,
   output logic                            axi_rvalid_o,
   input  logic                            axi_rready_i,
   output logic [cache_pkg::AXI_ID_W-1:0]  axi_rid_o,
   output logic                            axi_rlast_o
);

   integer                          seed = 32'h5916;
   logic                            busy_q;       // burst accepted, beats pending
   cache_pkg::addr_t                addr_q;
   logic [cache_pkg::AXI_LEN_W-1:0] len_q;
   logic [cache_pkg::AXI_LEN_W-1:0] beat_q;
   logic [1:0]                      dly_q;        // wait cycles before arready or rvalid
   logic                            err_armed_q;  // first burst to ERR_LINE still ahead
   cache_pkg::addr_t                beat_addr;
   cache_pkg::addr_t                hi_addr;

   assign beat_addr = addr_q + (cache_pkg::addr_t'(beat_q) << 3);
   assign hi_addr   = beat_addr + 16'd4;

   // each word holds its own address low and address xor pattern high
   assign axi_rdata_o = {hi_addr ^ 16'hc3a5, hi_addr, beat_addr ^ 16'hc3a5, beat_addr};
   assign axi_rlast_o = (beat_q == len_q);
   assign axi_rid_o   = '0;
   assign axi_rresp_o = (err_armed_q && beat_q == 8'd1 &&
                         addr_q[cache_pkg::ADDR_W-1 -: cache_pkg::LINE_ADDR_W] == ERR_LINE)
                        ? 2'b10 : 2'b00;  // SLVERR

   always @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         axi_arready_o <= 1'b0;
         axi_rvalid_o  <= 1'b0;
         busy_q        <= 1'b0;
         addr_q        <= '0;
         len_q         <= '0;
         beat_q        <= '0;
         dly_q         <= '0;
         err_armed_q   <= 1'b1;
      end else if (!busy_q) begin
         if (axi_arvalid_i && axi_arready_o) begin  // address handshake
            axi_arready_o <= 1'b0;
            addr_q        <= axi_araddr_i;
            len_q         <= axi_arlen_i;
            beat_q        <= '0;
            busy_q        <= 1'b1;
            dly_q         <= 2'($random(seed));
         end else if (axi_arvalid_i && dly_q == 2'd0) begin
            axi_arready_o <= 1'b1;
         end else if (axi_arvalid_i) begin
            dly_q <= dly_q - 2'd1;
         end
      end else if (axi_rvalid_o && axi_rready_i) begin
         axi_rvalid_o <= 1'b0;
         dly_q        <= 2'($random(seed));
         if (axi_rresp_o != 2'b00) begin
            err_armed_q <= 1'b0;  // only one failed beat per run
         end
         if (axi_rlast_o) begin
            busy_q <= 1'b0;
         end else begin
            beat_q <= beat_q + 8'd1;
         end
      end else if (dly_q == 2'd0) begin
         axi_rvalid_o <= 1'b1;  // held until rready
      end else begin
         dly_q <= dly_q - 2'd1;
      end
   end

endmodule

//--- cache_ctrl.sv
//####################################################################
// lookup controller: valid bits, tag compare, word select
// starts a line refill on a miss and replays the lookup afterwards
//####################################################################
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                  clk_i,
   input  logic                  reset_i,

   // core side
   input  logic                  req_i,
   input  cache_pkg::addr_t      req_addr_i,
   input  logic                  flush_i,
   output logic                  ready_o,
   output logic                  ack_o,
   output cache_pkg::word_t      rdata_o,

   // tag array
   output logic                  tag_we_o,
   output cache_pkg::tag_t       tag_wdata_o,
   input  cache_pkg::tag_t       tag_rdata_i,

   // shared RAM index and data array read side
   output cache_pkg::index_t     ram_index_o,
   output cache_pkg::beat_sel_t  data_rbeat_o,
   input  cache_pkg::beat_t      data_rdata_i,

   // refill engine
   output logic                  replace_valid_o,
   output cache_pkg::line_addr_t replace_addr_o,
   input  logic                  replace_i
);

   typedef enum logic [1:0] {
      st_idle,    // ready for a request
      st_lookup,  // RAM data valid, compare
      st_resp,    // ack with the selected word
      st_refill   // wait for the engine to finish
   } state_t;

   state_t                               state_q;
   cache_pkg::addr_t                     addr_q;   // request being served
   cache_pkg::word_t                     rdata_q;
   logic [(1 << cache_pkg::INDEX_W)-1:0] valid_q;  // one per line

   cache_pkg::tag_t      addr_tag;
   cache_pkg::index_t    addr_index;
   cache_pkg::beat_sel_t addr_beat;
   logic                 addr_word;  // upper or lower word of the beat
   cache_pkg::index_t    req_index;
   cache_pkg::beat_sel_t req_beat;
   logic                 hit;
   logic                 lookup_miss;

   // address fields of the held request
   assign addr_tag   = addr_q[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
   assign addr_index = addr_q[cache_pkg::ADDR_W-cache_pkg::TAG_W-1 -: cache_pkg::INDEX_W];
   assign addr_beat  = addr_q[cache_pkg::BEATS_W+cache_pkg::BEAT_BYTES_W-1 -: cache_pkg::BEATS_W];
   assign addr_word  = addr_q[cache_pkg::BEAT_BYTES_W-1];

   // same fields straight from the port, so the RAMs start on the request cycle
   assign req_index = req_addr_i[cache_pkg::ADDR_W-cache_pkg::TAG_W-1 -: cache_pkg::INDEX_W];
   assign req_beat  = req_addr_i[cache_pkg::BEATS_W+cache_pkg::BEAT_BYTES_W-1 -: cache_pkg::BEATS_W];

   assign ram_index_o  = (state_q == st_idle) ? req_index : addr_index;
   assign data_rbeat_o = (state_q == st_idle) ? req_beat : addr_beat;

   assign hit         = valid_q[addr_index] && (tag_rdata_i == addr_tag);
   assign lookup_miss = (state_q == st_lookup) && !hit;

   // a miss claims the line right away, the engine fills it in
   assign tag_we_o        = lookup_miss;
   assign tag_wdata_o     = addr_tag;
   assign replace_valid_o = lookup_miss;
   assign replace_addr_o  = addr_q[cache_pkg::ADDR_W-1 -: cache_pkg::LINE_ADDR_W];

   always_ff @(posedge clk_i) begin
      if (state_q == st_idle && req_i) begin
         addr_q <= req_addr_i;
      end
      if (state_q == st_lookup && hit) begin
         rdata_q <= data_rdata_i[addr_word*cache_pkg::WORD_W +: cache_pkg::WORD_W];
      end
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= st_idle;
         valid_q <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               if (flush_i) begin
                  valid_q <= '0;
               end
               if (req_i) begin
                  state_q <= st_lookup;
               end
            end
            st_lookup: begin
               if (hit) begin
                  state_q <= st_resp;
               end else begin
                  valid_q[addr_index] <= 1'b1;
                  state_q             <= st_refill;
               end
            end
            st_resp: state_q <= st_idle;
            default: begin
               // the RAMs already read addr_q this cycle, so replay the compare
               if (!replace_i) begin
                  state_q <= st_lookup;
               end
            end
         endcase
      end
   end

   assign ready_o = (state_q == st_idle);
   assign ack_o   = (state_q == st_resp);  // two cycles after req_i on a hit
   assign rdata_o = rdata_q;

endmodule

//--- cache_pkg.sv
//####################################################################
// cache geometry, address field types and AXI read constants
// shared by the lookup controller, the refill engine and the top level
//####################################################################
package cache_pkg;

   // core side
   localparam int ADDR_W = 16;  // byte address
   localparam int WORD_W = 32;

   // AXI beat and line shape
   localparam int BEAT_W       = 64;
   localparam int BEAT_BYTES_W = 3;  // 8 bytes per beat
   localparam int BEATS_W      = 1;  // two beats per 16-byte line

   // line organization, direct mapped
   localparam int INDEX_W     = 3;  // eight lines
   localparam int TAG_W       = ADDR_W - INDEX_W - BEATS_W - BEAT_BYTES_W;
   localparam int LINE_ADDR_W = TAG_W + INDEX_W;

   // AXI field widths
   localparam int AXI_ID_W  = 1;
   localparam int AXI_LEN_W = 8;

   // fixed AXI field values
   localparam logic [AXI_ID_W-1:0] AXI_ID_VAL     = '0;
   localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
   localparam logic [3:0]          AXI_CACHE_VAL  = 4'b0011;  // bufferable, modifiable
   localparam logic [1:0]          AXI_RESP_OKAY  = 2'b00;

   // address layout, msb first:
   //   tag | index | beat select | word in beat | byte
   typedef logic [ADDR_W-1:0]      addr_t;
   typedef logic [WORD_W-1:0]      word_t;
   typedef logic [BEAT_W-1:0]      beat_t;
   typedef logic [TAG_W-1:0]       tag_t;
   typedef logic [INDEX_W-1:0]     index_t;
   typedef logic [BEATS_W-1:0]     beat_sel_t;
   typedef logic [LINE_ADDR_W-1:0] line_addr_t;  // tag and index, no offset

endpackage

//--- cache_ram.sv
//####################################################################
// generic one-read one-write synchronous RAM
// serves as tag array and as line data array
//####################################################################
`timescale 1ns/1ps

module cache_ram #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH_W   = 3
) (
   input  logic               clk_i,
   input  logic               we_i,
   input  logic [DEPTH_W-1:0] waddr_i,
   input  payload_t           wdata_i,
   input  logic [DEPTH_W-1:0] raddr_i,
   output payload_t           rdata_o
);

   // storage, contents undefined until written
   payload_t mem [0:(1 << DEPTH_W)-1];

   // write port
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // registered read, data one cycle after the address
   // a same-address write in that cycle returns the old contents
   always_ff @(posedge clk_i) begin
      rdata_o <= mem[raddr_i];
   end

endmodule

//--- cache_read_channel_axi.sv
//####################################################################
// line refill engine, one AXI4 INCR burst per cache line
// beats go straight to the data array, failed bursts are reissued
//####################################################################
`timescale 1ns/1ps

module cache_read_channel_axi (
   input  logic                             clk_i,
   input  logic                             reset_i,

   // from the lookup controller
   input  logic                             replace_valid_i,
   input  cache_pkg::line_addr_t            replace_addr_i,
   output logic                             replace_o,

   // data array write port
   output logic                             read_valid_o,
   output cache_pkg::beat_sel_t             read_addr_o,
   output cache_pkg::beat_t                 read_rdata_o,

   // AXI read address channel
   output cache_pkg::addr_t                 axi_araddr_o,
   output logic [cache_pkg::AXI_ID_W-1:0]   axi_arid_o,
   output logic [cache_pkg::AXI_LEN_W-1:0]  axi_arlen_o,
   output logic [2:0]                       axi_arsize_o,
   output logic [1:0]                       axi_arburst_o,
   output logic                             axi_arlock_o,
   output logic [3:0]                       axi_arcache_o,
   output logic [2:0]                       axi_arprot_o,
   output logic [3:0]                       axi_arqos_o,
   output logic                             axi_arvalid_o,
   input  logic                             axi_arready_i,

   // AXI read data channel
   input  cache_pkg::beat_t                 axi_rdata_i,
   input  logic [1:0]                       axi_rresp_i,
   input  logic                             axi_rvalid_i,
   output logic                             axi_rready_o,
   input  logic [cache_pkg::AXI_ID_W-1:0]   axi_rid_i,
   input  logic                             axi_rlast_i
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,    // arvalid held until arready
      st_load,    // rready for the whole data phase
      st_settle   // last beat lands in the data array
   } state_t;

   state_t                state_q;
   cache_pkg::line_addr_t line_q;    // line being fetched
   cache_pkg::beat_sel_t  beat_q;    // beat number within the burst
   logic                  err_q;     // some beat of this burst failed
   logic                  beat_ok;

   // a beat with a foreign id counts as failed as well
   assign beat_ok = (axi_rresp_i == cache_pkg::AXI_RESP_OKAY) &&
                    (axi_rid_i == cache_pkg::AXI_ID_VAL);

   // line address, captured once per refill and kept across retries
   always_ff @(posedge clk_i) begin
      if (replace_valid_i && state_q == st_idle) begin
         line_q <= replace_addr_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= st_idle;
         beat_q  <= '0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (replace_valid_i) begin
                  state_q <= st_addr;
               end
            end
            st_addr: begin
               beat_q <= '0;   // fresh burst, also on a retry
               err_q  <= 1'b0;
               if (axi_arready_i) begin
                  state_q <= st_load;
               end
            end
            st_load: begin
               if (axi_rvalid_i) begin
                  if (!beat_ok) begin
                     err_q <= 1'b1;  // burst can't be cut short, drain it first
                  end
                  if (axi_rlast_i) begin
                     state_q <= st_settle;  // counter holds on the last beat
                  end else begin
                     beat_q <= beat_q + cache_pkg::beat_sel_t'(1);
                  end
               end
            end
            default: begin
               state_q <= err_q ? st_addr : st_idle;
            end
         endcase
      end
   end

   // burst shape: whole line, beat-wide transfers, incrementing
   assign axi_araddr_o  = {line_q, {(cache_pkg::BEATS_W + cache_pkg::BEAT_BYTES_W){1'b0}}};
   assign axi_arid_o    = cache_pkg::AXI_ID_VAL;
   assign axi_arlen_o   = {{(cache_pkg::AXI_LEN_W - cache_pkg::BEATS_W){1'b0}},
                           {cache_pkg::BEATS_W{1'b1}}};  // beats per line minus one
   assign axi_arsize_o  = 3'(cache_pkg::BEAT_BYTES_W);
   assign axi_arburst_o = cache_pkg::AXI_BURST_INCR;
   assign axi_arlock_o  = 1'b0;
   assign axi_arcache_o = cache_pkg::AXI_CACHE_VAL;
   assign axi_arprot_o  = 3'b000;
   assign axi_arqos_o   = 4'b0000;

   assign axi_arvalid_o = (state_q == st_addr);
   assign axi_rready_o  = (state_q == st_load);
   assign replace_o     = (state_q != st_idle);

   // every accepted beat is written, bad ones get overwritten on the retry
   assign read_valid_o = axi_rvalid_i && (state_q == st_load);
   assign read_addr_o  = beat_q;
   assign read_rdata_o = axi_rdata_i;

endmodule

//--- cache_sva.sv
//####################################################################
// AXI handshake assertions for the line refill engine
//####################################################################
`timescale 1ns/1ps

module cache_sva (
   input logic             clk_i,
   input logic             reset_i,
   input logic             replace_valid_i,
   input logic             replace_i,
   input cache_pkg::addr_t araddr_i,
   input logic             arvalid_i,
   input logic             arready_i,
   input logic             rvalid_i,
   input logic             rready_i,
   input logic             rlast_i
);

   logic pending_q;  // refill asked for, last beat not yet taken

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
      end else if (replace_valid_i) begin
         pending_q <= 1'b1;
      end else if (rvalid_i && rready_i && rlast_i) begin
         pending_q <= 1'b0;
      end
   end

   ar_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_i && !arready_i |=> $stable(araddr_i))
      else $error("araddr changed while arvalid waited for arready");

   ar_r_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
      !(arvalid_i && rready_i))
      else $error("arvalid and rready high in the same cycle");

   replace_held: assert property (@(posedge clk_i) disable iff (reset_i)
      pending_q |-> replace_i)
      else $error("replace_o dropped before the last beat was accepted");

endmodule

bind cache_read_channel_axi cache_sva i_cache_sva (
   .clk_i           (clk_i),
   .reset_i         (reset_i),
   .replace_valid_i (replace_valid_i),
   .replace_i       (replace_o),
   .araddr_i        (axi_araddr_o),
   .arvalid_i       (axi_arvalid_o),
   .arready_i       (axi_arready_i),
   .rvalid_i        (axi_rvalid_i),
   .rready_i        (axi_rready_o),
   .rlast_i         (axi_rlast_i)
);

//--- cache_tb.sv
//####################################################################
// testbench for the direct-mapped cache with AXI line refill
// applies a table of reads and flushes and checks the data rule
//####################################################################
`timescale 1ns/1ps

module cache_tb;

   localparam int                    TIMEOUT  = 200;     // cycles per wait
   localparam cache_pkg::line_addr_t ERR_LINE = 12'h2a3;  // first burst gets SLVERR

   typedef struct packed {
      logic             flush;
      cache_pkg::addr_t addr;
      logic             miss;  // refill expected
      logic [1:0]       ars;   // AR handshakes expected
   } entry_t;

   logic                            clk_i, reset_i, req_i, flush_i;
   logic                            ready_o, ack_o;
   cache_pkg::addr_t                req_addr_i, axi_araddr_o;
   cache_pkg::word_t                rdata_o;
   logic [cache_pkg::AXI_ID_W-1:0]  axi_arid_o, axi_rid_i;
   logic [cache_pkg::AXI_LEN_W-1:0] axi_arlen_o;
   logic [2:0]                      axi_arsize_o, axi_arprot_o;
   logic [1:0]                      axi_arburst_o, axi_rresp_i;
   logic [3:0]                      axi_arcache_o, axi_arqos_o;
   logic                            axi_arlock_o, axi_arvalid_o, axi_arready_i;
   cache_pkg::beat_t                axi_rdata_i;
   logic                            axi_rvalid_i, axi_rready_o, axi_rlast_i;
   int                              ar_count;
   cache_pkg::addr_t                cur_addr;  // address of the read in flight
   entry_t                          stim_q[$];

   cache_top i_cache_top (.*);

   axi_rom_model #(.ERR_LINE(ERR_LINE)) i_axi_rom_model (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .axi_araddr_i  (axi_araddr_o),
      .axi_arlen_i   (axi_arlen_o),
      .axi_arvalid_i (axi_arvalid_o),
      .axi_arready_o (axi_arready_i),
      .axi_rdata_o   (axi_rdata_i),
      .axi_rresp_o   (axi_rresp_i),
      .axi_rvalid_o  (axi_rvalid_i),
      .axi_rready_i  (axi_rready_o),
      .axi_rid_o     (axi_rid_i),
      .axi_rlast_o   (axi_rlast_i)
   );

   always @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         ar_count <= 0;
      end else if (axi_arvalid_o && axi_arready_i) begin
         check_ar({cur_addr[15:4], 4'h0});  // refill always starts at the line base
         ar_count <= ar_count + 1;
      end
   end

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                             input cache_pkg::addr_t addr);
      if (got !== exp) begin
         stop_run($sformatf("Error: %0t: read 0x%04h gave 0x%08h, expected 0x%08h",
                            $time, addr, got, exp));
      end
   endtask

   task automatic check_miss(input bit got, input bit exp, input cache_pkg::addr_t addr);
      if (got !== exp) begin
         stop_run($sformatf("Error: %0t: read 0x%04h miss %0b, expected %0b",
                            $time, addr, got, exp));
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         stop_run($sformatf("Error: %0t: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   // one line per burst: two 8-byte beats, INCR, id 0, normal cacheable access
   task automatic check_ar(input cache_pkg::addr_t exp_addr);
      if (axi_araddr_o !== exp_addr || axi_arid_o !== 1'b0 || axi_arlen_o !== 8'd1 ||
          axi_arsize_o !== 3'd3 || axi_arburst_o !== 2'b01 || axi_arlock_o !== 1'b0 ||
          axi_arcache_o !== 4'b0011 || axi_arprot_o !== 3'b000 ||
          axi_arqos_o !== 4'b0000) begin
         stop_run($sformatf({"Error: %0t: AR addr 0x%04h id %0h len %0d size %0d burst %0d",
                             " lock %0b cache %0h prot %0h qos %0h, expected addr 0x%04h"},
                            $time, axi_araddr_o, axi_arid_o, axi_arlen_o, axi_arsize_o,
                            axi_arburst_o, axi_arlock_o, axi_arcache_o, axi_arprot_o,
                            axi_arqos_o, exp_addr));
      end
   endtask

   // word at an aligned address: the address low, address xor c3a5 high
   function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
      cache_pkg::addr_t w;
      w = {a[15:2], 2'b00};
      return {w ^ 16'hc3a5, w};
   endfunction

   function automatic entry_t read_entry(input cache_pkg::addr_t a, input logic miss,
                                         input logic [1:0] ars);
      return '{1'b0, a, miss, ars};
   endfunction

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready_o) begin
         @(posedge clk_i);
         #1;
         n++;
         if (n > TIMEOUT) stop_run("Timeout: ready_o stayed low");
      end
   endtask

   task automatic do_read(input entry_t e);
      int lat;
      int ars_before;
      wait_ready();
      ars_before = ar_count;
      cur_addr   = e.addr;
      req_i      = 1'b1;
      req_addr_i = e.addr;
      lat        = 0;
      do begin
         @(posedge clk_i);
         #1;
         req_i = 1'b0;
         lat++;
      end while (!ack_o && lat < TIMEOUT);
      if (!ack_o) stop_run("Timeout: no ack_o for a read request");
      check_word(rdata_o, expected_word(e.addr), e.addr);
      check_miss(ar_count != ars_before, e.miss, e.addr);
      check_count(ar_count - ars_before, int'(e.ars), "AR handshake count");
      if (!e.miss) check_count(lat, 2, "hit latency in cycles");
   endtask

   task automatic do_flush();
      wait_ready();
      flush_i = 1'b1;
      @(posedge clk_i);
      #1;
      flush_i = 1'b0;
   endtask

   initial begin
      reset_i    = 1'b1;
      req_i      = 1'b0;
      req_addr_i = '0;
      flush_i    = 1'b0;
      cur_addr   = '0;
      // all eight lines: first word refills, the other three hit
      for (int i = 0; i < 8; i++) begin
         for (int w = 0; w < 4; w++) begin
            stim_q.push_back(read_entry(16'h0100 + 16'(16 * i + 4 * w), w == 0,
                                        (w == 0) ? 2'd1 : 2'd0));
         end
      end
      stim_q.push_back(read_entry(16'h0900, 1'b1, 2'd1));  // new tag at index 0
      stim_q.push_back(read_entry(16'h0104, 1'b1, 2'd1));  // old line comes back
      stim_q.push_back(read_entry(16'h090c, 1'b1, 2'd1));
      stim_q.push_back(read_entry(16'h0908, 1'b0, 2'd0));
      stim_q.push_back(entry_t'{1'b1, 16'h0000, 1'b0, 2'd0});  // flush
      stim_q.push_back(read_entry(16'h0114, 1'b1, 2'd1));
      stim_q.push_back(read_entry(16'h0118, 1'b0, 2'd0));
      stim_q.push_back(read_entry(16'h2a38, 1'b1, 2'd2));  // burst retried once
      stim_q.push_back(read_entry(16'h2a30, 1'b0, 2'd0));
      stim_q.push_back(read_entry(16'h2a3c, 1'b0, 2'd0));
      repeat (2) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      foreach (stim_q[k]) begin
         if (stim_q[k].flush) begin
            do_flush();
         end else begin
            do_read(stim_q[k]);
         end
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- cache_top.sv
//####################################################################
// direct-mapped read-only cache with AXI4 line refill
//####################################################################
`timescale 1ns/1ps

module cache_top (
   input  logic                             clk_i,
   input  logic                             reset_i,

   // core side
   input  logic                             req_i,
   input  cache_pkg::addr_t                 req_addr_i,
   input  logic                             flush_i,
   output logic                             ready_o,
   output logic                             ack_o,
   output cache_pkg::word_t                 rdata_o,

   // AXI read master
   output cache_pkg::addr_t                 axi_araddr_o,
   output logic [cache_pkg::AXI_ID_W-1:0]   axi_arid_o,
   output logic [cache_pkg::AXI_LEN_W-1:0]  axi_arlen_o,
   output logic [2:0]                       axi_arsize_o,
   output logic [1:0]                       axi_arburst_o,
   output logic                             axi_arlock_o,
   output logic [3:0]                       axi_arcache_o,
   output logic [2:0]                       axi_arprot_o,
   output logic [3:0]                       axi_arqos_o,
   output logic                             axi_arvalid_o,
   input  logic                             axi_arready_i,
   input  cache_pkg::beat_t                 axi_rdata_i,
   input  logic [1:0]                       axi_rresp_i,
   input  logic                             axi_rvalid_i,
   output logic                             axi_rready_o,
   input  logic [cache_pkg::AXI_ID_W-1:0]   axi_rid_i,
   input  logic                             axi_rlast_i
);

   logic                  tag_we;
   cache_pkg::tag_t       tag_wdata;
   cache_pkg::tag_t       tag_rdata;
   cache_pkg::index_t     ram_index;
   cache_pkg::beat_sel_t  data_rbeat;
   cache_pkg::beat_t      data_rdata;
   logic                  replace_valid;
   cache_pkg::line_addr_t replace_addr;
   logic                  replace;
   logic                  read_valid;
   cache_pkg::beat_sel_t  read_addr;
   cache_pkg::beat_t      read_rdata;

   cache_ctrl i_cache_ctrl (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .req_i           (req_i),
      .req_addr_i      (req_addr_i),
      .flush_i         (flush_i),
      .ready_o         (ready_o),
      .ack_o           (ack_o),
      .rdata_o         (rdata_o),
      .tag_we_o        (tag_we),
      .tag_wdata_o     (tag_wdata),
      .tag_rdata_i     (tag_rdata),
      .ram_index_o     (ram_index),
      .data_rbeat_o    (data_rbeat),
      .data_rdata_i    (data_rdata),
      .replace_valid_o (replace_valid),
      .replace_addr_o  (replace_addr),
      .replace_i       (replace)
   );

   cache_read_channel_axi i_read_channel (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .replace_valid_i (replace_valid),
      .replace_addr_i  (replace_addr),
      .replace_o       (replace),
      .read_valid_o    (read_valid),
      .read_addr_o     (read_addr),
      .read_rdata_o    (read_rdata),
      .axi_araddr_o    (axi_araddr_o),
      .axi_arid_o      (axi_arid_o),
      .axi_arlen_o     (axi_arlen_o),
      .axi_arsize_o    (axi_arsize_o),
      .axi_arburst_o   (axi_arburst_o),
      .axi_arlock_o    (axi_arlock_o),
      .axi_arcache_o   (axi_arcache_o),
      .axi_arprot_o    (axi_arprot_o),
      .axi_arqos_o     (axi_arqos_o),
      .axi_arvalid_o   (axi_arvalid_o),
      .axi_arready_i   (axi_arready_i),
      .axi_rdata_i     (axi_rdata_i),
      .axi_rresp_i     (axi_rresp_i),
      .axi_rvalid_i    (axi_rvalid_i),
      .axi_rready_o    (axi_rready_o),
      .axi_rid_i       (axi_rid_i),
      .axi_rlast_i     (axi_rlast_i)
   );

   // one tag per line
   cache_ram #(
      .payload_t (cache_pkg::tag_t),
      .DEPTH_W   (cache_pkg::INDEX_W)
   ) i_tag_ram (
      .clk_i   (clk_i),
      .we_i    (tag_we),
      .waddr_i (ram_index),
      .wdata_i (tag_wdata),
      .raddr_i (ram_index),
      .rdata_o (tag_rdata)
   );

   // one entry per beat, addressed by line index then beat number
   cache_ram #(
      .payload_t (cache_pkg::beat_t),
      .DEPTH_W   (cache_pkg::INDEX_W + cache_pkg::BEATS_W)
   ) i_data_ram (
      .clk_i   (clk_i),
      .we_i    (read_valid),
      .waddr_i ({ram_index, read_addr}),   // index stays on the missing line
      .wdata_i (read_rdata),
      .raddr_i ({ram_index, data_rbeat}),
      .rdata_o (data_rdata)
   );

endmodule

//--- filelist.f
cache_pkg.sv
cache_ram.sv
cache_read_channel_axi.sv
cache_ctrl.sv
cache_top.sv
axi_rom_model.sv
cache_sva.sv
cache_tb.sv
